//--- src.f
rtl/img_pkg.sv
rtl/img_ctrl_regs.sv
rtl/img_pattern_gen.sv
rtl/img_downsample.sv
rtl/img_blur_stage.sv
rtl/img_upsample.sv
rtl/img_filter_top.sv
sim/tb_img_filter.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module tb_img_filter -Mdir obj_dir -o tb_img_filter

./obj_dir/tb_img_filter

//--- sim/tb_img_filter.sv
`default_nettype none

module tb_img_filter;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int IMG_WIDTH      = 16;
  localparam int IMG_HEIGHT     = 4;
  localparam int NUM_STAGES     = 2;
  localparam int HALF_WIDTH     = IMG_WIDTH / 2;
  localparam int FRAME_BEATS    = IMG_WIDTH * IMG_HEIGHT;
  localparam int TIMEOUT_CYCLES = 4 * FRAME_BEATS * 4 + 500;
  localparam logic [31:0] SEED  = 32'hff282a0d;
  localparam logic [7:0] LEVEL  = 8'hc3;

  logic               stc_img_clock;
  logic               rst_n;
  img_pkg::axil_req_t axil_req;
  img_pkg::axil_rsp_t axil_rsp;
  img_pkg::pix_beat_t out_beat;
  logic               out_valid;
  logic               out_ready;
  logic               busy;

  img_pkg::pix_beat_t exp_frame [FRAME_BEATS];
  img_pkg::pix_beat_t exp_beat;
  img_pkg::pix_beat_t last_beat;  // out_beat one clock earlier
  int                 beat_idx;
  int                 frames_seen;
  int                 cycle_cnt;
  logic [31:0]        rng_state;
  logic [31:0]        rd_data;
  logic               start_accept;
  logic               eof_accept;

  img_filter_top #(
    .IMG_WIDTH  (IMG_WIDTH),
    .IMG_HEIGHT (IMG_HEIGHT),
    .NUM_STAGES (NUM_STAGES)
  ) i_dut (
    .stc_img_clock (stc_img_clock),
    .rst_n         (rst_n),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .out_beat      (out_beat),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .busy          (busy)
  );

  initial begin
    stc_img_clock = 1'b0;
    forever #10 stc_img_clock = ~stc_img_clock;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else report_failure($sformatf("FAIL %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Random back-pressure with ready about three cycles in four
  initial begin
    out_ready = 1'b0;
    rng_state = SEED;
    forever begin
      @(negedge stc_img_clock);
      if (rst_n) begin
        rng_state = xorshift32(rng_state);
        out_ready = (rng_state[1:0] != 2'b00);
      end
    end
  end

  // Expected output frame from generator, pair average, blur chain and pixel doubling
  task automatic build_expected(input img_pkg::pattern_e pat, input logic [7:0] level);
    int row  [IMG_WIDTH];
    int half [HALF_WIDTH];
    int blur [HALF_WIDTH];
    int left;
    int right;
    int idx;
    for (int y = 0; y < IMG_HEIGHT; y++) begin
      for (int x = 0; x < IMG_WIDTH; x++) begin
        case (pat)
          img_pkg::PAT_RAMP:    row[x] = (x + y) % 256;
          img_pkg::PAT_CHECKER: row[x] = (((x / 8) + (y / 8)) % 2 == 1) ? 255 : 0;
          default:              row[x] = int'(level);
        endcase
      end
      for (int j = 0; j < HALF_WIDTH; j++) begin
        half[j] = (row[2 * j] + row[2 * j + 1]) / 2;
      end
      for (int s = 0; s < NUM_STAGES; s++) begin
        for (int j = 0; j < HALF_WIDTH; j++) begin
          left    = (j == 0) ? half[j] : half[j - 1];  // Edge replication
          right   = (j == HALF_WIDTH - 1) ? half[j] : half[j + 1];
          blur[j] = (left + 2 * half[j] + right + 2) / 4;
        end
        half = blur;
      end
      for (int x = 0; x < IMG_WIDTH; x++) begin
        idx                = y * IMG_WIDTH + x;
        exp_frame[idx].data = 8'(half[x / 2]);
        exp_frame[idx].eol  = (x == IMG_WIDTH - 1);
        exp_frame[idx].eof  = (x == IMG_WIDTH - 1) && (y == IMG_HEIGHT - 1);
      end
    end
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
    @(negedge stc_img_clock);
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    @(posedge stc_img_clock);
    while (!axil_rsp.awready) @(posedge stc_img_clock);
    @(negedge stc_img_clock);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    @(posedge stc_img_clock);
    while (!axil_rsp.bvalid) @(posedge stc_img_clock);
    @(negedge stc_img_clock);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
    @(negedge stc_img_clock);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    @(posedge stc_img_clock);
    while (!axil_rsp.arready) @(posedge stc_img_clock);
    @(negedge stc_img_clock);
    axil_req.arvalid = 1'b0;
    @(posedge stc_img_clock);
    while (!axil_rsp.rvalid) @(posedge stc_img_clock);
    data = axil_rsp.rdata;
    @(negedge stc_img_clock);
    axil_req.rready = 1'b0;
  endtask

  task automatic wait_frames(input int count);
    while (frames_seen != count) @(posedge stc_img_clock);
  endtask

  // Returns once count beats of the current frame have left the output
  task automatic sync_to_beat(input int count);
    while (beat_idx < count) @(posedge stc_img_clock);
  endtask

  // Beat counter, stall history and the run limit
  always @(posedge stc_img_clock or negedge rst_n) begin
    if (!rst_n) begin
      beat_idx    <= 0;
      frames_seen <= 0;
      cycle_cnt   <= 0;
      last_beat   <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      last_beat <= out_beat;
      if (out_valid && out_ready) begin
        if (out_beat.eof) begin
          beat_idx    <= 0;
          frames_seen <= frames_seen + 1;
        end else begin
          beat_idx <= beat_idx + 1;
        end
      end
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        report_failure($sformatf("Timeout, the run did not end within %0d cycles",
                                 TIMEOUT_CYCLES));
      end
    end
  end

  assign exp_beat     = exp_frame[beat_idx];
  assign eof_accept   = out_valid & out_ready & out_beat.eof;
  assign start_accept = axil_req.awvalid & axil_rsp.awready & axil_req.wstrb[0] &
                        (axil_req.awaddr == img_pkg::REG_CTRL) & axil_req.wdata[0] & ~busy;

  a_out_matches_model: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    out_valid && out_ready |-> out_beat == exp_beat
  ) else report_failure($sformatf("FAIL out_beat[%0d] got 0x%03h expected 0x%03h",
                                  $sampled(beat_idx), $sampled(out_beat), $sampled(exp_beat)));

  a_beat_in_frame: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    out_valid |-> beat_idx < FRAME_BEATS
  ) else report_failure("More output beats than one frame holds");

  a_stall_stable: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && out_beat == last_beat
  ) else report_failure($sformatf("FAIL out_beat during stall got 0x%03h expected 0x%03h",
                                  $sampled(out_beat), $sampled(last_beat)));

  // Address and data channels are accepted in the same cycle
  a_w_with_aw: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    axil_rsp.wready == axil_rsp.awready
  ) else report_failure($sformatf("FAIL wready got 0x%01h expected 0x%01h",
                                  $sampled(axil_rsp.wready), $sampled(axil_rsp.awready)));

  a_bresp_okay: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    axil_rsp.bvalid |-> axil_rsp.bresp == img_pkg::AXI_RESP_OKAY
  ) else report_failure($sformatf("FAIL bresp got 0x%01h expected 0x0",
                                  $sampled(axil_rsp.bresp)));

  a_rresp_okay: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    axil_rsp.rvalid |-> axil_rsp.rresp == img_pkg::AXI_RESP_OKAY
  ) else report_failure($sformatf("FAIL rresp got 0x%01h expected 0x0",
                                  $sampled(axil_rsp.rresp)));

  a_idle_no_beats: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    out_valid |-> busy
  ) else report_failure("Output beat seen while no frame was running");

  a_busy_after_start: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    start_accept |=> busy
  ) else report_failure("Busy did not rise the cycle after an accepted start");

  // Held until the eof beat leaves, dropped right after it
  a_busy_holds: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    busy && !eof_accept |=> busy
  ) else report_failure("Busy fell before the eof beat was accepted");

  a_busy_falls: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    eof_accept |=> !busy
  ) else report_failure("Busy stayed high after the eof beat was accepted");

  initial begin
    rst_n    = 1'b0;
    axil_req = '0;
    repeat (10) @(posedge stc_img_clock);
    @(negedge stc_img_clock);
    rst_n = 1'b1;
    check_value("out_valid", 32'(out_valid), 32'd0);
    check_value("bvalid", 32'(axil_rsp.bvalid), 32'd0);
    check_value("rvalid", 32'(axil_rsp.rvalid), 32'd0);
    check_value("busy", 32'(busy), 32'd0);

    // Register readback without a start
    axil_write(img_pkg::REG_CONST, {24'd0, LEVEL});
    axil_write(img_pkg::REG_CTRL, {29'd0, img_pkg::PAT_CHECKER, 1'b0});
    axil_read(img_pkg::REG_CONST, rd_data);
    check_value("CONST", rd_data, {24'd0, LEVEL});
    axil_read(img_pkg::REG_CTRL, rd_data);
    check_value("CTRL", rd_data, 32'h0000_0002);
    axil_read(img_pkg::REG_STATUS, rd_data);
    check_value("STATUS", rd_data, 32'h0000_0000);
    axil_read(4'hc, rd_data);  // Unmapped
    check_value("unmapped", rd_data, 32'h0000_0000);

    build_expected(img_pkg::PAT_RAMP, LEVEL);
    axil_write(img_pkg::REG_CTRL, {29'd0, img_pkg::PAT_RAMP, 1'b1});
    wait_frames(1);
    axil_read(img_pkg::REG_STATUS, rd_data);
    check_value("STATUS", rd_data, 32'h0000_0100);

    build_expected(img_pkg::PAT_CHECKER, LEVEL);
    axil_write(img_pkg::REG_CTRL, {29'd0, img_pkg::PAT_CHECKER, 1'b1});
    wait_frames(2);
    axil_read(img_pkg::REG_STATUS, rd_data);
    check_value("STATUS", rd_data, 32'h0000_0200);

    // Constant frame with a second start that must be dropped
    build_expected(img_pkg::PAT_CONST, LEVEL);
    axil_write(img_pkg::REG_CTRL, {29'd0, img_pkg::PAT_CONST, 1'b1});
    check_value("busy", 32'(busy), 32'd1);
    // Generator already idle here while the last output beats still drain
    sync_to_beat(FRAME_BEATS - 4);
    axil_write(img_pkg::REG_CTRL, {29'd0, img_pkg::PAT_CONST, 1'b1});
    wait_frames(3);
    repeat (20) @(posedge stc_img_clock);
    axil_read(img_pkg::REG_STATUS, rd_data);
    check_value("STATUS", rd_data, 32'h0000_0300);
    check_value("frames_seen", 32'(frames_seen), 32'd3);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/img_filter_top.sv
`default_nettype none

module img_filter_top #(
  parameter int IMG_WIDTH  = 16,
  parameter int IMG_HEIGHT = 4,
  parameter int NUM_STAGES = 2
) (
  input  wire logic               stc_img_clock,
  input  wire logic               rst_n,
  input  wire img_pkg::axil_req_t axil_req,
  output img_pkg::axil_rsp_t      axil_rsp,
  output img_pkg::pix_beat_t      out_beat,
  output logic                    out_valid,
  input  wire logic               out_ready,
  output logic                    busy
);

  logic               start;
  img_pkg::pattern_e  pattern;
  img_pkg::pixel_t    const_level;
  wire                frame_done;

  img_pkg::pix_beat_t gen_beat;
  logic               gen_valid;
  logic               gen_ready;

  // Element 0 is the downsampler output, element NUM_STAGES feeds the upsampler
  img_pkg::pix_beat_t chain_beat  [NUM_STAGES+1];
  logic               chain_valid [NUM_STAGES+1];
  logic               chain_ready [NUM_STAGES+1];

  assign frame_done = out_valid & out_ready & out_beat.eof;

  img_ctrl_regs i_regs (
    .stc_img_clock (stc_img_clock),
    .rst_n         (rst_n),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .frame_done    (frame_done),
    .start         (start),
    .pattern       (pattern),
    .const_level   (const_level),
    .busy          (busy)
  );

  img_pattern_gen #(
    .IMG_WIDTH  (IMG_WIDTH),
    .IMG_HEIGHT (IMG_HEIGHT)
  ) i_gen (
    .stc_img_clock (stc_img_clock),
    .rst_n         (rst_n),
    .start         (start),
    .pattern       (pattern),
    .const_level   (const_level),
    .beat          (gen_beat),
    .valid         (gen_valid),
    .ready         (gen_ready)
  );

  img_downsample i_down (
    .stc_img_clock (stc_img_clock),
    .rst_n         (rst_n),
    .in_beat       (gen_beat),
    .in_valid      (gen_valid),
    .in_ready      (gen_ready),
    .out_beat      (chain_beat[0]),
    .out_valid     (chain_valid[0]),
    .out_ready     (chain_ready[0])
  );

  for (genvar i = 0; i < NUM_STAGES; i++) begin : g_blur
    img_blur_stage i_blur (
      .stc_img_clock (stc_img_clock),
      .rst_n         (rst_n),
      .in_beat       (chain_beat[i]),
      .in_valid      (chain_valid[i]),
      .in_ready      (chain_ready[i]),
      .out_beat      (chain_beat[i+1]),
      .out_valid     (chain_valid[i+1]),
      .out_ready     (chain_ready[i+1])
    );
  end

  img_upsample i_up (
    .stc_img_clock (stc_img_clock),
    .rst_n         (rst_n),
    .in_beat       (chain_beat[NUM_STAGES]),
    .in_valid      (chain_valid[NUM_STAGES]),
    .in_ready      (chain_ready[NUM_STAGES]),
    .out_beat      (out_beat),
    .out_valid     (out_valid),
    .out_ready     (out_ready)
  );

endmodule

`default_nettype wire

//--- rtl/img_upsample.sv
`default_nettype none

module img_upsample (
  input  wire logic               stc_img_clock,
  input  wire logic               rst_n,
  input  wire img_pkg::pix_beat_t in_beat,
  input  wire logic               in_valid,
  output logic                    in_ready,
  output img_pkg::pix_beat_t      out_beat,
  output logic                    out_valid,
  input  wire logic               out_ready
);

  logic phase;  // High on the second copy

  assign out_valid = in_valid;

  // Row and frame flags held back to the second copy
  assign out_beat = '{
    data: in_beat.data,
    eol:  in_beat.eol & phase,
    eof:  in_beat.eof & phase
  };

  // Input pixel is consumed only once both copies are out
  assign in_ready = phase && out_ready;

  always_ff @(posedge stc_img_clock or negedge rst_n) begin
    if (!rst_n) begin
      phase <= 1'b0;
    end else if (out_valid && out_ready) begin
      phase <= ~phase;
    end
  end

endmodule

`default_nettype wire

//--- rtl/img_blur_stage.sv
`default_nettype none

module img_blur_stage (
  input  wire logic               stc_img_clock,
  input  wire logic               rst_n,
  input  wire img_pkg::pix_beat_t in_beat,
  input  wire logic               in_valid,
  output logic                    in_ready,
  output img_pkg::pix_beat_t      out_beat,
  output logic                    out_valid,
  input  wire logic               out_ready
);

  typedef enum logic [1:0] {
    FIRST,  // Waiting for the first pixel of a row
    MID,    // Previous and current pixel held
    FLUSH   // Row ended, last pixel still to send
  } row_state_e;

  row_state_e         state;
  img_pkg::pixel_t    prev_q;
  img_pkg::pix_beat_t cur_q;
  logic               load;
  logic               in_fire;

  // 1-2-1 kernel with rounding
  function automatic img_pkg::pixel_t gauss3(input img_pkg::pixel_t l,
                                             input img_pkg::pixel_t c,
                                             input img_pkg::pixel_t r);
    logic [9:0] acc;
    acc = {2'b00, l} + {1'b0, c, 1'b0} + {2'b00, r} + 10'd2;
    return acc[9:2];
  endfunction

  assign load     = !out_valid || out_ready;
  assign in_ready = (state == FIRST) || (state == MID && load);
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge stc_img_clock or negedge rst_n) begin
    if (!rst_n) begin
      state     <= FIRST;
      out_valid <= 1'b0;
    end else begin
      if (out_valid && out_ready) out_valid <= 1'b0;

      case (state)
        FIRST: begin
          if (in_fire) state <= in_beat.eol ? FLUSH : MID;
        end
        MID: begin
          if (in_fire) begin
            out_valid <= 1'b1;
            if (in_beat.eol) state <= FLUSH;
          end
        end
        FLUSH: begin
          if (load) begin
            out_valid <= 1'b1;
            state     <= FIRST;
          end
        end
        default: state <= FIRST;
      endcase
    end
  end

  always_ff @(posedge stc_img_clock) begin
    case (state)
      FIRST: begin
        if (in_fire) begin
          prev_q <= in_beat.data;  // Left edge replicated
          cur_q  <= in_beat;
        end
      end
      MID: begin
        if (in_fire) begin
          out_beat.data <= gauss3(prev_q, cur_q.data, in_beat.data);
          out_beat.eol  <= 1'b0;
          out_beat.eof  <= 1'b0;
          prev_q        <= cur_q.data;
          cur_q         <= in_beat;
        end
      end
      FLUSH: begin
        if (load) begin
          // Right edge replicated, flags of the row end go out here
          out_beat.data <= gauss3(prev_q, cur_q.data, cur_q.data);
          out_beat.eol  <= cur_q.eol;
          out_beat.eof  <= cur_q.eof;
        end
      end
      default: ;
    endcase
  end

  a_out_stable: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_beat)
  ) else $error("Blur output changed during a stall");

endmodule

`default_nettype wire

//--- rtl/img_downsample.sv
`default_nettype none

module img_downsample (
  input  wire logic               stc_img_clock,
  input  wire logic               rst_n,
  input  wire img_pkg::pix_beat_t in_beat,
  input  wire logic               in_valid,
  output logic                    in_ready,
  output img_pkg::pix_beat_t      out_beat,
  output logic                    out_valid,
  input  wire logic               out_ready
);

  logic            phase;    // High while the first pixel of a pair is held
  img_pkg::pixel_t first_q;
  logic [8:0]      pair_sum;
  logic            load;
  logic            in_fire;

  assign load     = !out_valid || out_ready;
  // First pixel only goes into the holding register
  assign in_ready = !phase || load;
  assign in_fire  = in_valid && in_ready;
  assign pair_sum = {1'b0, first_q} + {1'b0, in_beat.data};

  always_ff @(posedge stc_img_clock or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (in_fire) phase <= ~phase;

      if (in_fire && phase) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge stc_img_clock) begin
    if (in_fire && !phase) begin
      first_q <= in_beat.data;
    end
    if (in_fire && phase) begin
      out_beat.data <= pair_sum[8:1];  // Floor of the mean
      out_beat.eol  <= in_beat.eol;
      out_beat.eof  <= in_beat.eof;
    end
  end

  // Rows must hold an even number of pixels
  a_pair_aligned: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    in_fire && !phase |-> !in_beat.eol
  ) else $error("eol on the first pixel of a pair");

endmodule

`default_nettype wire

//--- rtl/img_pattern_gen.sv
`default_nettype none

module img_pattern_gen #(
  parameter int IMG_WIDTH  = 16,
  parameter int IMG_HEIGHT = 4
) (
  input  wire logic              stc_img_clock,
  input  wire logic              rst_n,
  input  wire logic              start,
  input  wire img_pkg::pattern_e pattern,
  input  wire img_pkg::pixel_t   const_level,
  output img_pkg::pix_beat_t     beat,
  output logic                   valid,
  input  wire logic              ready
);

  localparam int XW = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;
  localparam int YW = (IMG_HEIGHT > 1) ? $clog2(IMG_HEIGHT) : 1;

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e            state;
  logic [XW-1:0]     x_cnt;
  logic [YW-1:0]     y_cnt;
  img_pkg::pattern_e pat_q;
  img_pkg::pixel_t   const_q;
  logic              last_x;
  logic              last_y;
  logic [31:0]       x_ext;
  logic [31:0]       y_ext;
  img_pkg::pixel_t   pix;

  assign last_x = (x_cnt == XW'(IMG_WIDTH - 1));
  assign last_y = (y_cnt == YW'(IMG_HEIGHT - 1));
  assign x_ext  = 32'(x_cnt);
  assign y_ext  = 32'(y_cnt);

  always_comb begin
    case (pat_q)
      img_pkg::PAT_RAMP:    pix = img_pkg::pixel_t'(x_ext + y_ext);  // Wraps at 256
      // 8x8 tiles, parity of the tile sum is the xor of bit 3
      img_pkg::PAT_CHECKER: pix = (x_ext[3] ^ y_ext[3]) ? 8'hff : 8'h00;
      default:              pix = const_q;
    endcase
  end

  assign valid    = (state == RUN);
  assign beat     = '{data: pix, eol: last_x, eof: last_x & last_y};

  always_ff @(posedge stc_img_clock or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      x_cnt <= '0;
      y_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= RUN;
            x_cnt <= '0;
            y_cnt <= '0;
          end
        end
        RUN: begin
          if (ready) begin
            if (last_x) begin
              x_cnt <= '0;
              if (last_y) state <= IDLE;  // Frame finished
              else        y_cnt <= y_cnt + 1'b1;
            end else begin
              x_cnt <= x_cnt + 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Frame settings frozen for the whole frame
  always_ff @(posedge stc_img_clock) begin
    if (state == IDLE && start) begin
      pat_q   <= pattern;
      const_q <= const_level;
    end
  end

  a_beat_stable: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    valid && !ready |=> valid && $stable(beat)
  ) else $error("Pattern beat changed during a stall");

endmodule

`default_nettype wire

//--- rtl/img_ctrl_regs.sv
`default_nettype none

module img_ctrl_regs (
  input  wire logic               stc_img_clock,
  input  wire logic               rst_n,
  input  wire img_pkg::axil_req_t axil_req,
  output img_pkg::axil_rsp_t      axil_rsp,
  input  wire logic               frame_done,
  output logic                    start,
  output img_pkg::pattern_e       pattern,
  output img_pkg::pixel_t         const_level,
  output logic                    busy
);

  logic              aw_fire;
  logic              ar_fire;
  logic              bvalid_q;
  logic              rvalid_q;
  logic [31:0]       rdata_q;
  logic [31:0]       rd_mux;
  logic [7:0]        frame_cnt;
  img_pkg::pattern_e pattern_q;
  img_pkg::pixel_t   const_q;
  logic              busy_q;
  logic              start_q;

  // Address and data accepted together with one write in flight at most
  assign aw_fire = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
  assign ar_fire = axil_req.arvalid & ~rvalid_q;

  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = aw_fire;
    axil_rsp.wready  = aw_fire;
    axil_rsp.bresp   = img_pkg::AXI_RESP_OKAY;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.arready = ~rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = img_pkg::AXI_RESP_OKAY;
    axil_rsp.rvalid  = rvalid_q;
  end

  // Write path and frame control
  always_ff @(posedge stc_img_clock or negedge rst_n) begin
    if (!rst_n) begin
      bvalid_q  <= 1'b0;
      start_q   <= 1'b0;
      busy_q    <= 1'b0;
      frame_cnt <= '0;
      pattern_q <= img_pkg::PAT_RAMP;
      const_q   <= '0;
    end else begin
      start_q <= 1'b0;  // Single cycle pulse

      if (aw_fire) begin
        bvalid_q <= 1'b1;
      end else if (bvalid_q && axil_req.bready) begin
        bvalid_q <= 1'b0;
      end

      if (aw_fire && axil_req.wstrb[0]) begin
        case (axil_req.awaddr)
          img_pkg::REG_CTRL: begin
            pattern_q <= img_pkg::pattern_e'(axil_req.wdata[2:1]);
            if (axil_req.wdata[0] && !busy_q) begin
              start_q <= 1'b1;
              busy_q  <= 1'b1;
            end
          end
          img_pkg::REG_CONST: const_q <= axil_req.wdata[7:0];
          default: ;  // Unmapped offset drops the write
        endcase
      end

      // Frame leaves the output port
      if (frame_done) begin
        busy_q    <= 1'b0;
        frame_cnt <= frame_cnt + 8'd1;
      end
    end
  end

  always_comb begin
    case (axil_req.araddr)
      img_pkg::REG_CTRL:   rd_mux = {29'd0, pattern_q, 1'b0};  // Start reads as zero
      img_pkg::REG_CONST:  rd_mux = {24'd0, const_q};
      img_pkg::REG_STATUS: rd_mux = {16'd0, frame_cnt, 7'd0, busy_q};
      default:             rd_mux = '0;
    endcase
  end

  // Read path
  always_ff @(posedge stc_img_clock or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else if (ar_fire) begin
      rvalid_q <= 1'b1;
    end else if (rvalid_q && axil_req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge stc_img_clock) begin
    if (ar_fire) begin
      rdata_q <= rd_mux;
    end
  end

  assign start       = start_q;
  assign pattern     = pattern_q;
  assign const_level = const_q;
  assign busy        = busy_q;

  // A write response needs a full address and data handshake one cycle earlier
  a_bvalid_after_write: assert property (
    @(posedge stc_img_clock) disable iff (!rst_n)
    $rose(axil_rsp.bvalid) |->
      $past(axil_req.awvalid && axil_req.wvalid && axil_rsp.awready && axil_rsp.wready)
  ) else $error("bvalid rose without an accepted write");

endmodule

`default_nettype wire

//--- rtl/img_pkg.sv
`default_nettype none

package img_pkg;

  // One grayscale pixel
  typedef logic [7:0] pixel_t;

  // Stream beat shared by every block in the filter path
  typedef struct packed {
    pixel_t data;
    logic   eol;  // Last pixel of a row
    logic   eof;  // Last pixel of the frame
  } pix_beat_t;

  // Pattern opcodes held in CTRL bits 2:1
  typedef enum logic [1:0] {
    PAT_RAMP    = 2'd0,
    PAT_CHECKER = 2'd1,
    PAT_CONST   = 2'd2
  } pattern_e;

  // Master side of the register port
  typedef struct packed {
    logic [3:0]  awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        rready;
  } axil_req_t;

  // Slave side of the register port
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

  // Register byte offsets
  localparam logic [3:0] REG_CTRL   = 4'h0;
  localparam logic [3:0] REG_CONST  = 4'h4;
  localparam logic [3:0] REG_STATUS = 4'h8;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire
